// File: Makefile
TOP = tpu_ctrl_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -sv --top-module $(TOP) -Mdir obj_dir -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// File: all.f
design/tpu_ctrl_pkg.sv
design/cmd_queue.sv
design/weight_sequencer.sv
design/activation_sequencer.sv
design/writeback_tracker.sv
design/tpu_ctrl_top.sv
testbench/tpu_ctrl_tb.sv

// File: design/activation_sequencer.sv
`timescale 1ns/1ns

module activation_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              a_start,
    input  logic [tpu_ctrl_pkg::addr_w-1:0]   a_addr_a,
    input  logic [tpu_ctrl_pkg::addr_w-1:0]   a_addr_d,
    output logic                              rd_en_a,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   rd_addr_a,
    output logic                              a_valid,
    output logic                              a_switch,
    output logic                              wb_push,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   wb_addr_d,
    output logic                              active
);

    // counts 0..15 over the reads, 16 on the handoff cycle
    logic [tpu_ctrl_pkg::cnt_w-1:0] cnt;

    assign wb_push = active && (int'(cnt) == tpu_ctrl_pkg::array_w);

    // ========================================
    // burst control
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            cnt      <= '0;
            rd_en_a  <= 1'b0;
            a_switch <= 1'b0;
            a_valid  <= 1'b0;
        end else begin
            a_switch <= 1'b0;
            a_valid  <= rd_en_a;

            if (a_start) begin
                // also taken on the handoff cycle of the previous burst
                active   <= 1'b1;
                cnt      <= '0;
                rd_en_a  <= 1'b1;
                a_switch <= 1'b1;
            end else if (active) begin
                if (wb_push) begin
                    active <= 1'b0;
                end else begin
                    cnt <= cnt + 1'b1;
                    if (int'(cnt) == tpu_ctrl_pkg::array_w - 1) begin
                        rd_en_a <= 1'b0;
                    end
                end
            end
        end
    end

    // ========================================
    // addresses
    // ========================================
    always_ff @(posedge clk) begin
        if (a_start) begin
            rd_addr_a <= a_addr_a;
            wb_addr_d <= a_addr_d;
        end else if (rd_en_a) begin
            rd_addr_a <= rd_addr_a + 1'b1;
        end
    end

    // weight stage spacing must leave room for a full burst
    a_start_when_free: assert property (
        @(posedge clk) disable iff (rst) a_start |-> (!active || wb_push)
    );

endmodule

// File: design/cmd_queue.sv
`timescale 1ns/1ns

module cmd_queue (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cmd_valid,
    input  logic [tpu_ctrl_pkg::cmd_w-1:0]    cmd_data,
    input  logic                              q_pop,
    output logic                              cmd_ready,
    output logic                              q_valid,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   q_addr_a,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   q_addr_b,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   q_addr_d,
    output logic [7:0]                        q_len_k,
    output logic [7:0]                        q_len_n
);

    logic [tpu_ctrl_pkg::cmd_w-1:0] mem [4];
    logic [tpu_ctrl_pkg::cmd_w-1:0] head;
    logic [1:0]                     wr_ptr;
    logic [1:0]                     rd_ptr;
    logic [2:0]                     count;
    logic                           push;

    assign cmd_ready = (count != 3'd4);
    assign q_valid   = (count != 3'd0);
    assign push      = cmd_valid && cmd_ready;

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_data;
        end
    end

    // head command split into fields
    assign head     = mem[rd_ptr];
    assign q_addr_a = head[tpu_ctrl_pkg::cmd_addr_a_lsb +: tpu_ctrl_pkg::addr_w];
    assign q_addr_b = head[tpu_ctrl_pkg::cmd_addr_b_lsb +: tpu_ctrl_pkg::addr_w];
    assign q_addr_d = head[tpu_ctrl_pkg::cmd_addr_d_lsb +: tpu_ctrl_pkg::addr_w];
    assign q_len_k  = head[tpu_ctrl_pkg::cmd_len_k_lsb +: 8];
    assign q_len_n  = head[tpu_ctrl_pkg::cmd_len_n_lsb +: 8];

    // the weight stage must only take a command that is there
    a_pop_not_empty: assert property (@(posedge clk) disable iff (rst) q_pop |-> q_valid);

endmodule

// File: design/tpu_ctrl_pkg.sv
package tpu_ctrl_pkg;

    // ========================================
    // array and datapath sizes
    // ========================================

    // systolic array is square, rows == columns
    localparam int array_w = 16;

    // scratchpad address width
    localparam int addr_w = 10;

    // wide enough to hold array_w itself
    localparam int cnt_w = 5;

    // weight row index
    localparam int idx_w = 4;

    localparam int cmd_w = 64;

    // ========================================
    // command field positions
    // ========================================

    // three 8-bit lengths at the bottom
    localparam int cmd_len_m_lsb = 0;
    localparam int cmd_len_k_lsb = cmd_len_m_lsb + 8;
    localparam int cmd_len_n_lsb = cmd_len_k_lsb + 8;

    // then four scratchpad addresses
    localparam int cmd_addr_a_lsb = cmd_len_n_lsb + 8;
    localparam int cmd_addr_b_lsb = cmd_addr_a_lsb + addr_w;
    // addr_c sits between b and d and is not decoded
    localparam int cmd_addr_d_lsb = cmd_addr_b_lsb + 2 * addr_w;

    // ========================================
    // weight stage states
    // ========================================
    typedef enum logic [1:0] {
        idle,
        load,
        gap
    } weight_state_t;

endpackage

// File: design/tpu_ctrl_top.sv
`timescale 1ns/1ns

module tpu_ctrl_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cmd_valid,
    input  logic [tpu_ctrl_pkg::cmd_w-1:0]    cmd_data,
    input  logic                              core_wb_valid,
    output logic                              cmd_ready,
    output logic                              busy,
    output logic                              done_irq,
    output logic                              rd_en_b,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   rd_addr_b,
    output logic                              accept_w,
    output logic [tpu_ctrl_pkg::idx_w-1:0]    weight_index,
    output logic                              rd_en_a,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   rd_addr_a,
    output logic                              a_valid,
    output logic                              a_switch,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   wr_addr_d,
    output logic [tpu_ctrl_pkg::array_w-1:0]  row_mask,
    output logic [tpu_ctrl_pkg::array_w-1:0]  col_mask
);

    // queue head
    logic                            q_valid;
    logic                            q_pop;
    logic [tpu_ctrl_pkg::addr_w-1:0] q_addr_a;
    logic [tpu_ctrl_pkg::addr_w-1:0] q_addr_b;
    logic [tpu_ctrl_pkg::addr_w-1:0] q_addr_d;
    logic [7:0]                      q_len_k;
    logic [7:0]                      q_len_n;

    // stage handoffs
    logic                            a_start;
    logic [tpu_ctrl_pkg::addr_w-1:0] a_addr_a;
    logic [tpu_ctrl_pkg::addr_w-1:0] a_addr_d;
    logic                            wb_push;
    logic [tpu_ctrl_pkg::addr_w-1:0] wb_addr_d;

    logic                            w_active;
    logic                            a_active;
    logic                            pending;

    assign busy = q_valid | w_active | a_active | pending;

    cmd_queue u_cmd_queue (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_data(cmd_data),
        .q_pop(q_pop), .cmd_ready(cmd_ready), .q_valid(q_valid),
        .q_addr_a(q_addr_a), .q_addr_b(q_addr_b), .q_addr_d(q_addr_d),
        .q_len_k(q_len_k), .q_len_n(q_len_n)
    );

    weight_sequencer u_weight_sequencer (
        .clk(clk), .rst(rst), .q_valid(q_valid), .q_addr_a(q_addr_a),
        .q_addr_b(q_addr_b), .q_addr_d(q_addr_d), .q_len_k(q_len_k),
        .q_len_n(q_len_n), .busy(busy), .q_pop(q_pop), .rd_en_b(rd_en_b),
        .rd_addr_b(rd_addr_b), .accept_w(accept_w), .weight_index(weight_index),
        .row_mask(row_mask), .col_mask(col_mask), .a_start(a_start),
        .a_addr_a(a_addr_a), .a_addr_d(a_addr_d), .active(w_active)
    );

    activation_sequencer u_activation_sequencer (
        .clk(clk), .rst(rst), .a_start(a_start), .a_addr_a(a_addr_a),
        .a_addr_d(a_addr_d), .rd_en_a(rd_en_a), .rd_addr_a(rd_addr_a),
        .a_valid(a_valid), .a_switch(a_switch), .wb_push(wb_push),
        .wb_addr_d(wb_addr_d), .active(a_active)
    );

    writeback_tracker u_writeback_tracker (
        .clk(clk), .rst(rst), .wb_push(wb_push), .wb_addr_d(wb_addr_d),
        .core_wb_valid(core_wb_valid), .wr_addr_d(wr_addr_d),
        .done_irq(done_irq), .pending(pending)
    );

endmodule

// File: design/weight_sequencer.sv
`timescale 1ns/1ns

module weight_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              q_valid,
    input  logic [tpu_ctrl_pkg::addr_w-1:0]   q_addr_a,
    input  logic [tpu_ctrl_pkg::addr_w-1:0]   q_addr_b,
    input  logic [tpu_ctrl_pkg::addr_w-1:0]   q_addr_d,
    input  logic [7:0]                        q_len_k,
    input  logic [7:0]                        q_len_n,
    input  logic                              busy,
    output logic                              q_pop,
    output logic                              rd_en_b,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   rd_addr_b,
    output logic                              accept_w,
    output logic [tpu_ctrl_pkg::idx_w-1:0]    weight_index,
    output logic [tpu_ctrl_pkg::array_w-1:0]  row_mask,
    output logic [tpu_ctrl_pkg::array_w-1:0]  col_mask,
    output logic                              a_start,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   a_addr_a,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   a_addr_d,
    output logic                              active
);

    tpu_ctrl_pkg::weight_state_t     state;
    logic [tpu_ctrl_pkg::cnt_w-1:0]  cnt;
    logic [tpu_ctrl_pkg::array_w-1:0] row_mask_q;
    logic [tpu_ctrl_pkg::array_w-1:0] col_mask_q;

    // lowest len bits set, saturating at the array width
    function automatic logic [tpu_ctrl_pkg::array_w-1:0] thermo(input logic [7:0] len);
        logic [tpu_ctrl_pkg::array_w-1:0] m;
        for (int i = 0; i < tpu_ctrl_pkg::array_w; i++) begin
            m[i] = (i < int'(len));
        end
        return m;
    endfunction

    // next command can start from idle or straight out of the gap
    assign q_pop   = q_valid && (state != tpu_ctrl_pkg::load);
    assign a_start = (state == tpu_ctrl_pkg::gap);
    assign active  = (state != tpu_ctrl_pkg::idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= tpu_ctrl_pkg::idle;
            cnt          <= '0;
            rd_en_b      <= 1'b0;
            accept_w     <= 1'b0;
            weight_index <= '0;
            row_mask_q   <= '0;
            col_mask_q   <= '0;
        end else begin
            case (state)
                tpu_ctrl_pkg::load: begin
                    cnt <= cnt + 1'b1;
                    // 16th read on the bus now
                    if (int'(cnt) == tpu_ctrl_pkg::array_w - 1) begin
                        rd_en_b <= 1'b0;
                        state   <= tpu_ctrl_pkg::gap;
                    end
                end
                default: begin
                    if (q_pop) begin
                        state   <= tpu_ctrl_pkg::load;
                        cnt     <= '0;
                        rd_en_b <= 1'b1;
                    end else begin
                        state <= tpu_ctrl_pkg::idle;
                    end
                end
            endcase

            if (q_pop) begin
                row_mask_q <= thermo(q_len_k);
                col_mask_q <= thermo(q_len_n);
            end

            // core side lags the read by one cycle, index counts down
            accept_w <= rd_en_b;
            if (rd_en_b) begin
                weight_index <= accept_w ? weight_index - 1'b1 : '1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            rd_addr_b <= q_addr_b;
            a_addr_a  <= q_addr_a;
            a_addr_d  <= q_addr_d;
        end else if (rd_en_b) begin
            rd_addr_b <= rd_addr_b + 1'b1;
        end
    end

    // masks hold across stage gaps until all work drains
    assign row_mask = busy ? row_mask_q : '0;
    assign col_mask = busy ? col_mask_q : '0;

endmodule

// File: design/writeback_tracker.sv
`timescale 1ns/1ns

module writeback_tracker (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wb_push,
    input  logic [tpu_ctrl_pkg::addr_w-1:0]   wb_addr_d,
    input  logic                              core_wb_valid,
    output logic [tpu_ctrl_pkg::addr_w-1:0]   wr_addr_d,
    output logic                              done_irq,
    output logic                              pending
);

    // destination queue, head entry is the one being written
    logic [tpu_ctrl_pkg::addr_w-1:0] dq_mem [4];
    logic [1:0]                      wr_ptr;
    logic [1:0]                      rd_ptr;
    logic [2:0]                      count;
    logic                            full;

    // rows already written for the head entry
    logic [tpu_ctrl_pkg::addr_w-1:0] row_off;
    logic                            row_hit;
    logic                            retire;

    assign pending = (count != 3'd0);
    assign full    = (count == 3'd4);
    assign row_hit = core_wb_valid && pending;
    assign retire  = row_hit && (int'(row_off) == tpu_ctrl_pkg::array_w - 1);

    // address steps from the head destination
    assign wr_addr_d = dq_mem[rd_ptr] + row_off;

    // ========================================
    // queue and row counter
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            row_off  <= '0;
            done_irq <= 1'b0;
        end else begin
            done_irq <= retire;

            if (wb_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (row_hit) begin
                row_off <= retire ? '0 : row_off + 1'b1;
            end

            // 16th row frees the head
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wb_push, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_push) begin
            dq_mem[wr_ptr] <= wb_addr_d;
        end
    end

    // a slow core must not let destinations pile past four
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wb_push |-> !full);

endmodule

// File: testbench/tpu_ctrl_tb.sv
`timescale 1ns/1ns

module tpu_ctrl_tb;

    localparam int n_cmds = 12;
    // 17 cycles per command in the weight stage, with a wide margin
    localparam int wd_cycles = n_cmds * 17 * 4 + 200;

    logic                                     clk;
    logic                                     rst;
    logic                                     cmd_valid;
    logic [tpu_ctrl_pkg::cmd_w-1:0]           cmd_data;
    logic                                     core_wb_valid = 1'b0;
    logic                                     cmd_ready;
    logic                                     busy;
    logic                                     done_irq;
    logic                                     rd_en_b;
    logic [tpu_ctrl_pkg::addr_w-1:0]          rd_addr_b;
    logic                                     accept_w;
    logic [tpu_ctrl_pkg::idx_w-1:0]           weight_index;
    logic                                     rd_en_a;
    logic [tpu_ctrl_pkg::addr_w-1:0]          rd_addr_a;
    logic                                     a_valid;
    logic                                     a_switch;
    logic [tpu_ctrl_pkg::addr_w-1:0]          wr_addr_d;
    logic [tpu_ctrl_pkg::array_w-1:0]         row_mask;
    logic [tpu_ctrl_pkg::array_w-1:0]         col_mask;

    // ========================================
    // reference model state
    // ========================================
    int seed = 32'h2ff8;
    int errors = 0;
    int checks = 0;
    int len_k [n_cmds];
    int len_n [n_cmds];
    int addr_a [n_cmds];
    int addr_b [n_cmds];
    int addr_d [n_cmds];
    logic [tpu_ctrl_pkg::cmd_w-1:0] cmd_word [n_cmds];

    // command indices waiting for each stage, destinations waiting for rows
    int w_q[$];
    int a_q[$];
    int d_q[$];
    int wb_q[$];
    int accepted = 0;
    int pops = 0;
    int dones = 0;
    int w_cnt = 0;
    int a_cnt = 0;
    int av_cnt = 0;
    int wb_rows = 0;
    int w_cur = 0;
    int a_cur = 0;
    int idx_exp = 0;
    logic prev_rd_en_b = 1'b0;
    logic prev_rd_en_a = 1'b0;
    logic done_exp = 1'b0;

    task automatic compare_value(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic require_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("at %0t: %s", $time, msg);
        end
    endtask

    // lowest len bits set, all ones from 16 up
    function automatic int thermo_code(input int len);
        if (len >= 16) begin
            return 32'hffff;
        end
        return (1 << len) - 1;
    endfunction

    tpu_ctrl_top u_tpu_ctrl_top (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_data(cmd_data),
        .core_wb_valid(core_wb_valid),
        .cmd_ready(cmd_ready),
        .busy(busy),
        .done_irq(done_irq),
        .rd_en_b(rd_en_b),
        .rd_addr_b(rd_addr_b),
        .accept_w(accept_w),
        .weight_index(weight_index),
        .rd_en_a(rd_en_a),
        .rd_addr_a(rd_addr_a),
        .a_valid(a_valid),
        .a_switch(a_switch),
        .wr_addr_d(wr_addr_d),
        .row_mask(row_mask),
        .col_mask(col_mask)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // core returns rows on about three of four cycles, denser when the queue backs up
    always @(posedge clk) begin
        if (rst) begin
            core_wb_valid <= 1'b0;
        end else begin
            core_wb_valid <= (wb_q.size() != 0)
                && (wb_q.size() >= 3 || ($random(seed) & 3) != 0);
        end
    end

    // ========================================
    // monitor, sampled on the falling edge
    // ========================================
    always @(negedge clk) begin
        if (!rst) begin
            // weight stage
            compare_value(int'(accept_w), int'(prev_rd_en_b), "accept_w");
            if (accept_w) begin
                compare_value(int'(weight_index), idx_exp, "weight_index");
            end
            prev_rd_en_b = rd_en_b;
            if (rd_en_b) begin
                if (w_cnt == 0) begin
                    require_true(w_q.size() != 0, "weight reads started with no command waiting");
                    if (w_q.size() != 0) begin
                        w_cur = w_q.pop_front();
                    end
                    pops++;
                end
                compare_value(int'(rd_addr_b), (addr_b[w_cur] + w_cnt) % 1024, "rd_addr_b");
                compare_value(int'(row_mask), thermo_code(len_k[w_cur]), "row_mask");
                compare_value(int'(col_mask), thermo_code(len_n[w_cur]), "col_mask");
                idx_exp = 15 - w_cnt;
                w_cnt = (w_cnt + 1) % 16;
            end else begin
                require_true(w_cnt == 0, "weight read burst ended before 16 rows");
            end
            compare_value(int'(cmd_ready), int'(accepted - pops < 4), "cmd_ready");

            // activation stage
            compare_value(int'(a_valid), int'(prev_rd_en_a), "a_valid");
            prev_rd_en_a = rd_en_a;
            if (rd_en_a) begin
                if (a_cnt == 0) begin
                    require_true(a_q.size() != 0, "activation reads started with no command");
                    if (a_q.size() != 0) begin
                        a_cur = a_q.pop_front();
                    end
                    d_q.push_back(a_cur);
                end
                compare_value(int'(rd_addr_a), (addr_a[a_cur] + a_cnt) % 1024, "rd_addr_a");
                compare_value(int'(a_switch), int'(a_cnt == 0), "a_switch");
                a_cnt = (a_cnt + 1) % 16;
            end else begin
                compare_value(int'(a_switch), 0, "a_switch");
                require_true(a_cnt == 0, "activation read burst ended before 16 rows");
            end
            // 16th a_valid is the handoff cycle
            if (a_valid) begin
                av_cnt = (av_cnt + 1) % 16;
                if (av_cnt == 0 && d_q.size() != 0) begin
                    wb_q.push_back(addr_d[d_q.pop_front()]);
                end
            end

            // writeback stage
            compare_value(int'(done_irq), int'(done_exp), "done_irq");
            if (done_irq) begin
                dones++;
            end
            done_exp = 1'b0;
            if (core_wb_valid) begin
                require_true(wb_q.size() != 0, "result row arrived with no destination pending");
                if (wb_q.size() != 0) begin
                    compare_value(int'(wr_addr_d), (wb_q[0] + wb_rows) % 1024, "wr_addr_d");
                    wb_rows = (wb_rows + 1) % 16;
                    if (wb_rows == 0) begin
                        wb_q.delete(0);
                        done_exp = 1'b1;
                    end
                end
            end
        end
    end

    // ========================================
    // stimulus and end of run
    // ========================================
    initial begin
        int gap [n_cmds];
        int len_m;
        int addr_c;

        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_data = '0;

        // every command drawn up front
        for (int i = 0; i < n_cmds; i++) begin
            len_m = $unsigned($random(seed)) % 256;
            len_k[i] = $unsigned($random(seed)) % 21;
            len_n[i] = $unsigned($random(seed)) % 21;
            addr_a[i] = $unsigned($random(seed)) % 1024;
            addr_b[i] = $unsigned($random(seed)) % 1024;
            addr_c = $unsigned($random(seed)) % 1024;
            addr_d[i] = $unsigned($random(seed)) % 1024;
            gap[i] = $unsigned($random(seed)) % 6;
            cmd_word[i] = {10'(addr_d[i]), 10'(addr_c), 10'(addr_b[i]), 10'(addr_a[i]),
                           8'(len_n[i]), 8'(len_k[i]), 8'(len_m)};
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n_cmds; i++) begin
            repeat (gap[i]) @(posedge clk);
            cmd_valid <= 1'b1;
            cmd_data <= cmd_word[i];
            @(posedge clk);
            while (!cmd_ready) begin
                @(posedge clk);
            end
            w_q.push_back(i);
            a_q.push_back(i);
            accepted++;
            cmd_valid <= 1'b0;
        end

        // model drained once every stage has seen every command
        while (w_q.size() + a_q.size() + d_q.size() + wb_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(negedge clk);
        compare_value(int'(busy), 0, "busy after last done");
        compare_value(int'(row_mask), 0, "row_mask when idle");
        compare_value(int'(col_mask), 0, "col_mask when idle");
        compare_value(dones, accepted, "done pulse count");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d commands done, %0d errors",
                 wd_cycles, dones, n_cmds, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule
